//--- rtl/crc_macros.svh
// Build constants for the CRC checker. Only a 32-bit word over four 8-bit stages is supported
`ifndef CRC_MACROS_SVH
`define CRC_MACROS_SVH

// Generator polynomial, normal (unreflected) form
`define CRC_POLY 32'h04C11DB7

// Message word width in bits
`define CRC_DATA_W 32

// Width of the user tag that rides along with each word
`define CRC_TAG_W 4

// Engine depth
// The word width divided by this gives the bits handled per stage
`define CRC_STAGES 4

// Mismatch counter width, saturates at all ones
`define CRC_ERR_W 4

`endif

//--- rtl/crc_data_pkg.sv
// Data path types for the CRC checker. The CRC value is as wide as the data word
`include "crc_macros.svh"

package crc_data_pkg;

    // One message word, MSB is the first bit sent
    typedef logic [`CRC_DATA_W-1:0] crc_word_t;

    // Computed remainder or the check value received with a word
    typedef logic [`CRC_DATA_W-1:0] crc_value_t;

    // Opaque user tag, returned unchanged with the result
    typedef logic [`CRC_TAG_W-1:0] crc_tag_t;

endpackage

//--- rtl/crc_status_pkg.sv
// Status types for the CRC checker. The error count only clears on reset
`include "crc_macros.svh"

package crc_status_pkg;

    // Saturating count of words whose check value did not match
    typedef logic [`CRC_ERR_W-1:0] err_count_t;

    // High when the received value equals the computed CRC
    typedef logic match_t;

endpackage

//--- rtl/crc_result_if.sv
// Result path from the CRC engine to the compare stage. No back-pressure, fields valid only with valid
`timescale 1ns/1ns

interface crc_result_if import crc_data_pkg::*; ();

    bit         valid;
    crc_value_t crc;
    crc_value_t ref_crc;
    crc_tag_t   tag;

    // Engine side
    modport src (
        output valid,
        output crc,
        output ref_crc,
        output tag
    );

    // Compare side
    modport dst (
        input valid,
        input crc,
        input ref_crc,
        input tag
    );

endinterface

//--- rtl/crc_word_pipe.sv
// CRC-32 of one word (poly 04C11DB7, init 0, no reflection, no XOR-out). Five cycles of latency, no stall
`timescale 1ns/1ns
`include "crc_macros.svh"

module crc_word_pipe import crc_data_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  crc_word_t  in_word,
    input  crc_value_t in_ref,
    input  crc_tag_t   in_tag,
    crc_result_if.src  res
);

    localparam int         STAGES = `CRC_STAGES;
    localparam int         DATA_W = `CRC_DATA_W;
    localparam int         BITS   = DATA_W / STAGES;
    localparam int         CRC_W  = $bits(crc_value_t);
    localparam crc_value_t POLY   = `CRC_POLY;

    // Index 0 is the input capture, index k is the output of engine stage k
    logic [STAGES:0] vld;
    crc_value_t      ref_q [0:STAGES];
    crc_tag_t        tag_q [0:STAGES];

    // Message bits still to be consumed, next byte at the top
    crc_word_t       msg   [0:STAGES-1];

    // Partial remainder after each stage
    crc_value_t      rem   [1:STAGES];

    // Per-bit remainder chain inside each stage
    crc_value_t      chain [0:STAGES-1][0:BITS];

    genvar s, b;
    generate
        for (s = 0; s < STAGES; s++) begin : g_stage
            // First stage starts from the zero initial value
            if (s == 0) begin : g_seed
                assign chain[s][0] = '0;
            end else begin : g_carry
                assign chain[s][0] = rem[s];
            end

            for (b = 0; b < BITS; b++) begin : g_bit
                logic fb;

                // Feedback is the remainder MSB against the incoming message bit
                assign fb = chain[s][b][CRC_W-1] ^ msg[s][DATA_W-1-b];
                assign chain[s][b+1] = {chain[s][b][CRC_W-2:0], 1'b0} ^ (fb ? POLY : '0);
            end
        end
    endgenerate

    // Valid shift chain, one bit per register level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld <= '0;
        end else begin
            vld <= {vld[STAGES-1:0], in_valid};
        end
    end

    // Payload registers only load behind a valid word
    always_ff @(posedge clk) begin
        if (in_valid) begin
            msg[0]   <= in_word;
            ref_q[0] <= in_ref;
            tag_q[0] <= in_tag;
        end

        for (int k = 1; k <= STAGES; k++) begin
            if (vld[k-1]) begin
                rem[k]   <= chain[k-1][BITS];
                ref_q[k] <= ref_q[k-1];
                tag_q[k] <= tag_q[k-1];
            end
        end

        // Consumed byte drops off the top
        for (int k = 1; k < STAGES; k++) begin
            if (vld[k-1]) begin
                msg[k] <= msg[k-1] << BITS;
            end
        end
    end

    assign res.valid   = vld[STAGES];
    assign res.crc     = rem[STAGES];
    assign res.ref_crc = ref_q[STAGES];
    assign res.tag     = tag_q[STAGES];

    // A word leaving the engine must carry a fully known remainder
    a_valid_crc_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        res.valid |-> !$isunknown(res.crc)
    );

endmodule

//--- rtl/crc_match_unit.sv
// Registered compare of computed and received CRC. The mismatch count saturates and clears only on reset
`timescale 1ns/1ns

module crc_match_unit import crc_data_pkg::*, crc_status_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    crc_result_if.dst  res,
    output logic       out_valid,
    output crc_value_t out_crc,
    output match_t     out_match,
    output crc_tag_t   out_tag,
    output err_count_t err_count
);

    localparam err_count_t ERR_MAX = '1;

    match_t hit;

    assign hit = (res.crc == res.ref_crc);

    // Result strobe, one edge behind the engine
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= res.valid;
        end
    end

    // Result fields hold their last value between strobes
    always_ff @(posedge clk) begin
        if (res.valid) begin
            out_crc   <= res.crc;
            out_match <= hit;
            out_tag   <= res.tag;
        end
    end

    // Counts on the same edge that presents the failing result
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_count <= '0;
        end else if (res.valid && !hit && (err_count != ERR_MAX)) begin
            err_count <= err_count + err_count_t'(1);
        end
    end

    // Counter only moves up between resets
    a_count_monotonic: assert property (
        @(posedge clk) disable iff (!rst_n)
        err_count >= $past(err_count)
    );

    // A count step shows up together with the failing result it counts
    a_count_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        (err_count != $past(err_count)) |-> (out_valid && !out_match)
    );

endmodule

//--- rtl/crc_checker_top.sv
// Top of the CRC-32 word checker. One word per cycle at most, fixed six-cycle latency, no back-pressure
`timescale 1ns/1ns

module crc_checker_top import crc_data_pkg::*, crc_status_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  crc_word_t  in_word,
    input  crc_value_t in_ref,
    input  crc_tag_t   in_tag,
    output logic       out_valid,
    output crc_value_t out_crc,
    output match_t     out_match,
    output crc_tag_t   out_tag,
    output err_count_t err_count
);

    // Engine to compare stage
    crc_result_if res_if ();

    crc_word_pipe crc_word_pipe_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_word  (in_word),
        .in_ref   (in_ref),
        .in_tag   (in_tag),
        .res      (res_if.src)
    );

    crc_match_unit crc_match_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .res       (res_if.dst),
        .out_valid (out_valid),
        .out_crc   (out_crc),
        .out_match (out_match),
        .out_tag   (out_tag),
        .err_count (err_count)
    );

endmodule

//--- dv/crc_checker_tb.sv
// Testbench for the CRC checker. Runs from the project root, plays the vector file twice (back to back, then with random gaps)
`timescale 1ns/1ns

module crc_checker_tb import crc_data_pkg::*, crc_status_pkg::*; ();

    localparam int         CLK_PERIOD   = 20;
    localparam int         RESET_CYCLES = 10;
    localparam int         DRIVE_DELAY  = 2;
    localparam int         DRAIN_LIMIT  = 20;
    localparam int         NAME_CHARS   = 24;
    localparam err_count_t COUNT_MAX    = 4'd15;

    typedef logic [8*NAME_CHARS-1:0] test_name_t;

    typedef struct packed {
        test_name_t name;
        crc_word_t  word;
        crc_value_t ref_val;
        crc_tag_t   tag;
        crc_value_t crc;
        match_t     match;
    } test_rec_t;

    test_rec_t  tests[$];
    test_rec_t  pending[$];

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    crc_word_t  in_word;
    crc_value_t in_ref;
    crc_tag_t   in_tag;
    logic       out_valid;
    crc_value_t out_crc;
    match_t     out_match;
    crc_tag_t   out_tag;
    err_count_t err_count;

    err_count_t exp_count;
    int         n_strobes;
    bit         loaded;

    crc_checker_top crc_checker_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_word   (in_word),
        .in_ref    (in_ref),
        .in_tag    (in_tag),
        .out_valid (out_valid),
        .out_crc   (out_crc),
        .out_match (out_match),
        .out_tag   (out_tag),
        .err_count (err_count)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic end_in_failure();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_crc(input test_name_t name, input crc_value_t exp, input crc_value_t act);
        if (act !== exp) begin
            $display("[ERROR] %0s: out_crc expected %08h, actual %08h", name, exp, act);
            end_in_failure();
        end
    endtask

    task automatic check_tag(input test_name_t name, input crc_tag_t exp, input crc_tag_t act);
        if (act !== exp) begin
            $display("[ERROR] %0s: out_tag expected %h, actual %h", name, exp, act);
            end_in_failure();
        end
    endtask

    task automatic check_match(input test_name_t name, input match_t exp, input match_t act);
        if (act !== exp) begin
            $display("[ERROR] %0s: out_match expected %b, actual %b", name, exp, act);
            end_in_failure();
        end
    endtask

    task automatic check_count(input test_name_t name, input err_count_t exp,
                               input err_count_t act);
        if (act !== exp) begin
            $display("[ERROR] %0s: err_count expected %0d, actual %0d", name, exp, act);
            end_in_failure();
        end
    endtask

    // Lines starting with # are comments, every other line holds six fields
    task automatic load_tests();
        int         fd;
        int         code;
        int         n;
        string      line;
        test_rec_t  rec;
        test_name_t name;
        crc_word_t  word;
        crc_value_t ref_val;
        crc_tag_t   tag;
        crc_value_t crc;
        match_t     match;
        fd = $fopen("dv/crc_checker_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file dv/crc_checker_tests.txt");
            end_in_failure();
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code != 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                n = $sscanf(line, "%s %h %h %h %h %h", name, word, ref_val, tag, crc, match);
                if (n != 6) begin
                    $display("malformed line in test data file: %s", line);
                    end_in_failure();
                end
                rec.name    = name;
                rec.word    = word;
                rec.ref_val = ref_val;
                rec.tag     = tag;
                rec.crc     = crc;
                rec.match   = match;
                tests.push_back(rec);
            end
        end
        $fclose(fd);
        if (tests.size() == 0) begin
            $display("test data file holds no tests");
            end_in_failure();
        end
    endtask

    // One strobe, then junk on the data inputs while in_valid is low
    task automatic drive_one(input test_rec_t rec);
        in_valid = 1'b1;
        in_word  = rec.word;
        in_ref   = rec.ref_val;
        in_tag   = rec.tag;
        pending.push_back(rec);
        @(posedge clk);
        #DRIVE_DELAY;
        in_valid = 1'b0;
        in_word  = crc_word_t'($urandom);
        in_ref   = crc_value_t'($urandom);
        in_tag   = crc_tag_t'($urandom);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (pending.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
    endtask

    // Stimulus
    initial begin
        int seed_ret;
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_word   = '0;
        in_ref    = '0;
        in_tag    = '0;
        exp_count = '0;
        seed_ret  = $urandom(18837);
        load_tests();
        n_strobes = 2 * tests.size();
        loaded    = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        idle_cycles(2);

        // Back to back, no idle cycles
        foreach (tests[i]) begin
            drive_one(tests[i]);
        end

        // Same list again with random gaps
        foreach (tests[i]) begin
            idle_cycles(int'($urandom_range(3, 0)));
            drive_one(tests[i]);
        end

        wait_for_drain();
        idle_cycles(8);
        if (pending.size() != 0) begin
            $display("%0d results still missing at the end of the run", pending.size());
            end_in_failure();
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

    // Monitor, samples on the falling edge where outputs are settled
    initial begin
        test_rec_t exp;
        @(posedge clk);
        forever begin
            @(negedge clk);
            if (out_valid) begin
                if (pending.size() == 0) begin
                    $display("out_valid went high with no word outstanding");
                    end_in_failure();
                end else begin
                    exp = pending.pop_front();
                    if (!exp.match && exp_count != COUNT_MAX) begin
                        exp_count = exp_count + err_count_t'(1);
                    end
                    check_tag(exp.name, exp.tag, out_tag);
                    check_crc(exp.name, exp.crc, out_crc);
                    check_match(exp.name, exp.match, out_match);
                    check_count(exp.name, exp_count, err_count);
                end
            end else begin
                check_count("idle", exp_count, err_count);
            end
        end
    end

    // Watchdog, budget scales with the number of strobes
    initial begin
        wait (loaded);
        repeat (n_strobes * 4 + 50) @(posedge clk);
        $display("watchdog expired after %0d clock periods", n_strobes * 4 + 50);
        end_in_failure();
    end

endmodule

//--- dv/crc_checker_tests.txt
# name word received_value tag expected_crc expected_match, all numbers in hex
# expected_crc is the word times x^32 mod 04C11DB7 (init 0, unreflected, no XOR-out)
zero_word 00000000 00000000 0 00000000 1
all_ones FFFFFFFF C704DD7B 1 C704DD7B 1
bit00 00000001 04C11DB7 2 04C11DB7 1
bit01 00000002 09823B6E 3 09823B6E 1
bit07 00000080 690CE0EE 4 690CE0EE 1
bit08 00000100 D219C1DC 5 D219C1DC 1
bit15 00008000 828CD898 6 828CD898 1
bit16 00010000 01D8AC87 7 01D8AC87 1
bit23 00800000 EC564380 8 EC564380 1
bit24 01000000 DC6D9AB7 9 DC6D9AB7 1
bit30 40000000 D1139055 A D1139055 1
bit31 80000000 A6E63D1D B A6E63D1D 1
word_03 00000003 0D4326D9 C 0D4326D9 1
word_11 00000011 48D0C6C7 D 48D0C6C7 1
word_101 00000101 D6D8DC6B E D6D8DC6B 1
ends_set 80000001 A22720AA F A22720AA 1
bad_zero_ref1 00000000 00000001 0 00000000 0
bad_ones_lsb FFFFFFFF C704DD7A 1 C704DD7B 0
bad_ones_msb FFFFFFFF 4704DD7B 2 C704DD7B 0
bad_bit00_zero 00000001 00000000 3 04C11DB7 0
bad_bit00_swap 00000001 09823B6E 4 04C11DB7 0
bad_bit07 00000080 690CE0EF 5 690CE0EE 0
bad_bit08 00000100 D219C1DD 6 D219C1DC 0
bad_bit15 00008000 028CD898 7 828CD898 0
bad_bit16 00010000 01D8AC86 8 01D8AC87 0
bad_bit23 00800000 EC564381 9 EC564380 0
bad_bit24 01000000 DC6D9AB6 A DC6D9AB7 0
bad_bit30 40000000 D1139054 B D1139055 0
bad_bit31 80000000 A6E63D1C C A6E63D1D 0
bad_word_03 00000003 0D4326D8 D 0D4326D9 0
bad_word_11 00000011 48D0C6C6 E 48D0C6C7 0
bad_word_101 00000101 D6D8DC6A F D6D8DC6B 0
bad_ends_set 80000001 A22720AB 0 A22720AA 0
bad_zero_ones 00000000 FFFFFFFF 1 00000000 0
bad_ones_zero FFFFFFFF 00000000 2 C704DD7B 0
bad_bit01 00000002 09823B6F 3 09823B6E 0
bad_bit31_as30 80000000 D1139055 4 A6E63D1D 0
bad_word_03_inv 00000003 F2BCD926 5 0D4326D9 0
late_bit00 00000001 04C11DB7 6 04C11DB7 1
late_ones FFFFFFFF C704DD7B 7 C704DD7B 1

//--- sim.f
+incdir+rtl
rtl/crc_data_pkg.sv
rtl/crc_status_pkg.sv
rtl/crc_result_if.sv
rtl/crc_word_pipe.sv
rtl/crc_match_unit.sv
rtl/crc_checker_top.sv
dv/crc_checker_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the CRC checker testbench with Verilator and runs it.
# Exit status is the simulator's status: zero on pass, non-zero on any failure.

set -u

cd "$(dirname "$0")"
status=$?
if [ "$status" -ne 0 ]; then
    echo "cannot change to the project root"
    exit "$status"
fi

command -v verilator > /dev/null
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator not found on PATH"
    exit "$status"
fi

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f \
    --top-module crc_checker_tb \
    --Mdir obj_dir \
    -o crc_checker_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/crc_checker_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
else
    echo "simulation finished cleanly"
fi

exit "$status"
